// File: Makefile
# Verilator build and run of the ECC memory path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_hci_ecc_mem
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
hci_ecc_pkg.sv
secded_39_32_enc.sv
secded_39_32_dec.sv
hci_ecc_dec.sv
hci_ecc_enc.sv
hci_sram_bank.sv
hci_ecc_mem_top.sv
tb_hci_ecc_mem.sv

// File: hci_ecc_dec.sv
// ==========================================================
// target-side adapter: corrects and strips ECC on requests,
// encodes read data on responses, bank sits downstream
// ==========================================================

module hci_ecc_dec
  import hci_ecc_pkg::*;
(
  // upstream link side, data carries its check bits
  input  logic  req_i,
  output logic  gnt_o,
  input  addr_t add_i,
  input  logic  wen_i,
  input  be_t   be_i,
  input  data_t data_i,
  input  ecc_t  ecc_i,
  output logic  r_valid_o,
  output data_t r_data_o,
  output ecc_t  r_ecc_o,
  // downstream memory side, plain data
  output logic  mem_req_o,
  input  logic  mem_gnt_i,
  output addr_t mem_add_o,
  output logic  mem_wen_o,
  output be_t   mem_be_o,
  output data_t mem_data_o,
  input  logic  mem_r_valid_i,
  input  data_t mem_r_data_i,
  // write-side status, valid in the granted cycle
  output ecc_t  syndrome_o,
  output err_t  err_o
);

  // write data after single-bit correction
  data_t wdata_fix;

  // control fields pass straight through
  // grant is combinational back from the bank
  assign mem_req_o = req_i;
  assign gnt_o     = mem_gnt_i;
  assign mem_add_o = add_i;
  assign mem_wen_o = wen_i;
  assign mem_be_o  = be_i;

  // decode the incoming codeword, bank stores corrected data
  // double errors go through uncorrected, only reported
  secded_39_32_dec u_wr_dec (
    .data_i     (data_i),
    .ecc_i      (ecc_i),
    .data_o     (wdata_fix),
    .syndrome_o (syndrome_o),
    .err_o      (err_o)
  );

  assign mem_data_o = wdata_fix;

  // read data gets fresh check bits for the trip back
  secded_39_32_enc u_rd_enc (
    .data_i (mem_r_data_i),
    .ecc_o  (r_ecc_o)
  );

  assign r_data_o  = mem_r_data_i;
  assign r_valid_o = mem_r_valid_i;

endmodule

// File: hci_ecc_enc.sv
// ==========================================================
// initiator-side adapter: adds ECC to requests, checks and
// corrects read responses coming back over the link
// ==========================================================

module hci_ecc_enc
  import hci_ecc_pkg::*;
(
  // upstream initiator side, plain data
  input  logic  req_i,
  output logic  gnt_o,
  input  addr_t add_i,
  input  logic  wen_i,
  input  be_t   be_i,
  input  data_t data_i,
  output logic  r_valid_o,
  output data_t r_data_o,
  // link side, data travels with its check bits
  output logic  lnk_req_o,
  input  logic  lnk_gnt_i,
  output addr_t lnk_add_o,
  output logic  lnk_wen_o,
  output be_t   lnk_be_o,
  output data_t lnk_data_o,
  output ecc_t  lnk_ecc_o,
  input  logic  lnk_r_valid_i,
  input  data_t lnk_r_data_i,
  input  ecc_t  lnk_r_ecc_i,
  // read-side status, valid while r_valid_o is high
  output ecc_t  rd_syndrome_o,
  output err_t  rd_err_o
);

  // read data after single-bit correction
  data_t rdata_fix;

  // request handshake is passed through untouched
  assign lnk_req_o  = req_i;
  assign gnt_o      = lnk_gnt_i;
  assign lnk_add_o  = add_i;
  assign lnk_wen_o  = wen_i;
  assign lnk_be_o   = be_i;
  assign lnk_data_o = data_i;

  // check bits cover the full word, not just enabled bytes
  // reads also carry a codeword, target ignores it
  secded_39_32_enc u_wr_enc (
    .data_i (data_i),
    .ecc_o  (lnk_ecc_o)
  );

  // response codeword is checked on arrival
  secded_39_32_dec u_rd_dec (
    .data_i     (lnk_r_data_i),
    .ecc_i      (lnk_r_ecc_i),
    .data_o     (rdata_fix),
    .syndrome_o (rd_syndrome_o),
    .err_o      (rd_err_o)
  );

  // no response buffering, valid follows the link
  assign r_valid_o = lnk_r_valid_i;
  assign r_data_o  = rdata_fix;

endmodule

// File: hci_ecc_mem_top.sv
// ==========================================================
// ECC memory path top: initiator adapter, faultable link,
// target adapter and SRAM bank, flips are xored on the link
// ==========================================================

module hci_ecc_mem_top
  import hci_ecc_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  output logic                    gnt_o,
  input  addr_t                   add_i,
  input  logic                    wen_i,
  input  be_t                     be_i,
  input  data_t                   data_i,
  output logic                    rvalid_o,
  output data_t                   rdata_o,
  // codeword flip masks, ecc in the upper bits, data below
  input  logic [ECC_W+DATA_W-1:0] wr_flip_i,
  input  logic [ECC_W+DATA_W-1:0] rd_flip_i,
  output err_t                    wr_err_o,
  output ecc_t                    wr_syndrome_o,
  output err_t                    rd_err_o,
  output ecc_t                    rd_syndrome_o
);

  // link request, as driven by the initiator adapter
  logic  lnk_req, lnk_gnt, lnk_wen;
  addr_t lnk_add;
  be_t   lnk_be;
  data_t lnk_data;
  ecc_t  lnk_ecc;
  // request codeword after fault injection
  data_t lnk_data_f;
  ecc_t  lnk_ecc_f;
  // link response, before and after fault injection
  logic  lnk_r_valid;
  data_t lnk_r_data, lnk_r_data_f;
  ecc_t  lnk_r_ecc, lnk_r_ecc_f;
  // plain bank interface
  logic  mem_req, mem_gnt, mem_wen, mem_r_valid;
  addr_t mem_add;
  be_t   mem_be;
  data_t mem_data, mem_r_data;

  hci_ecc_enc u_ecc_enc (
    .req_i         (req_i),         .gnt_o         (gnt_o),
    .add_i         (add_i),         .wen_i         (wen_i),
    .be_i          (be_i),          .data_i        (data_i),
    .r_valid_o     (rvalid_o),      .r_data_o      (rdata_o),
    .lnk_req_o     (lnk_req),       .lnk_gnt_i     (lnk_gnt),
    .lnk_add_o     (lnk_add),       .lnk_wen_o     (lnk_wen),
    .lnk_be_o      (lnk_be),        .lnk_data_o    (lnk_data),
    .lnk_ecc_o     (lnk_ecc),       .lnk_r_valid_i (lnk_r_valid),
    .lnk_r_data_i  (lnk_r_data_f),  .lnk_r_ecc_i   (lnk_r_ecc_f),
    .rd_syndrome_o (rd_syndrome_o), .rd_err_o      (rd_err_o)
  );

  // fault injection, codeword bit 32+j is check bit j
  assign {lnk_ecc_f, lnk_data_f}     = {lnk_ecc, lnk_data} ^ wr_flip_i;
  assign {lnk_r_ecc_f, lnk_r_data_f} = {lnk_r_ecc, lnk_r_data} ^ rd_flip_i;

  hci_ecc_dec u_ecc_dec (
    .req_i         (lnk_req),       .gnt_o         (lnk_gnt),
    .add_i         (lnk_add),       .wen_i         (lnk_wen),
    .be_i          (lnk_be),        .data_i        (lnk_data_f),
    .ecc_i         (lnk_ecc_f),     .r_valid_o     (lnk_r_valid),
    .r_data_o      (lnk_r_data),    .r_ecc_o       (lnk_r_ecc),
    .mem_req_o     (mem_req),       .mem_gnt_i     (mem_gnt),
    .mem_add_o     (mem_add),       .mem_wen_o     (mem_wen),
    .mem_be_o      (mem_be),        .mem_data_o    (mem_data),
    .mem_r_valid_i (mem_r_valid),   .mem_r_data_i  (mem_r_data),
    .syndrome_o    (wr_syndrome_o), .err_o         (wr_err_o)
  );

  hci_sram_bank u_bank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (mem_req),
    .gnt_o     (mem_gnt),
    .add_i     (mem_add),
    .wen_i     (mem_wen),
    .be_i      (mem_be),
    .data_i    (mem_data),
    .r_valid_o (mem_r_valid),
    .r_data_o  (mem_r_data)
  );

endmodule

// File: hci_ecc_pkg.sv
// ==========================================================
// shared widths, vector types and the SECDED(39,32) column
// table, imported by every block of the ECC memory path
// ==========================================================

package hci_ecc_pkg;

  // data word and check-bit widths of the 39/32 code
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ECC_W     = 7;
  // word addressing into the bank
  localparam int unsigned ADDR_W    = 10;
  localparam int unsigned MEM_DEPTH = 1024;

  typedef logic [DATA_W-1:0]   data_t;
  // check bits, also used for syndromes
  typedef logic [ECC_W-1:0]    ecc_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  // one enable per byte lane
  typedef logic [DATA_W/8-1:0] be_t;
  // bit 0 corrected single error, bit 1 uncorrected double error
  typedef logic [1:0]          err_t;

  // column of data bit i in the parity-check matrix
  // weight-3 values in ascending order, first 32 of 35
  // check bit j owns the unit column with only bit j set
  localparam ecc_t ECC_COLUMNS [0:DATA_W-1] = '{
    7'h07, 7'h0b, 7'h0d, 7'h0e,
    7'h13, 7'h15, 7'h16, 7'h19,
    7'h1a, 7'h1c, 7'h23, 7'h25,
    7'h26, 7'h29, 7'h2a, 7'h2c,
    7'h31, 7'h32, 7'h34, 7'h38,
    7'h43, 7'h45, 7'h46, 7'h49,
    7'h4a, 7'h4c, 7'h51, 7'h52,
    7'h54, 7'h58, 7'h61, 7'h62
  };

endpackage

// File: hci_sram_bank.sv
// ==========================================================
// single-port word SRAM with byte enables, grants every
// request and returns read data one cycle later
// ==========================================================

module hci_sram_bank
  import hci_ecc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  req_i,
  output logic  gnt_o,
  input  addr_t add_i,
  input  logic  wen_i,
  input  be_t   be_i,
  input  data_t data_i,
  output logic  r_valid_o,
  output data_t r_data_o
);

  // storage array, one data word per address
  data_t mem [MEM_DEPTH];
  // registered read word
  data_t rdata_q;
  logic  rvalid_q;

  // never busy, grant mirrors the request
  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      if (!wen_i) begin
        // write, only enabled byte lanes change
        for (int b = 0; b < DATA_W / 8; b++) begin
          if (be_i[b]) begin
            mem[add_i][8*b +: 8] <= data_i[8*b +: 8];
          end
        end
      end else begin
        // wen high means read
        rdata_q <= mem[add_i];
      end
    end
  end

  // response valid pulses one cycle after a granted read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i && gnt_o && wen_i;
    end
  end

  assign r_valid_o = rvalid_q;
  assign r_data_o  = rdata_q;

endmodule

// File: secded_39_32_dec.sv
// ==========================================================
// SECDED(39,32) decoder: syndrome, single-bit correction and
// error class for one codeword, purely combinational
// ==========================================================

module secded_39_32_dec
  import hci_ecc_pkg::*;
(
  input  data_t data_i,
  input  ecc_t  ecc_i,
  output data_t data_o,
  output ecc_t  syndrome_o,
  output err_t  err_o
);

  // xor of the columns of all set codeword bits
  ecc_t  syndrome;
  // odd syndrome weight points at a single flipped bit
  logic  single_err;
  // corrected copy of the data part
  data_t data_fix;

  always_comb begin
    // check bits enter with their unit columns
    syndrome = ecc_i;
    for (int i = 0; i < DATA_W; i++) begin
      if (data_i[i]) begin
        syndrome = syndrome ^ ECC_COLUMNS[i];
      end
    end
  end

  assign single_err = ^syndrome;

  always_comb begin
    data_fix = data_i;
    // flip the one data bit whose column matches
    // a hit on a check bit has no data column, data stays as is
    for (int i = 0; i < DATA_W; i++) begin
      if (single_err && (syndrome == ECC_COLUMNS[i])) begin
        data_fix[i] = ~data_i[i];
      end
    end
  end

  always_comb begin
    if (syndrome == '0) begin
      // clean codeword
      err_o = 2'b00;
    end else if (single_err) begin
      // single error, corrected or sitting in the check bits
      err_o = 2'b01;
    end else begin
      // even nonzero weight, two bits flipped
      // data goes out as received
      err_o = 2'b10;
    end
  end

  assign data_o     = data_fix;
  assign syndrome_o = syndrome;

endmodule

// File: secded_39_32_enc.sv
// ==========================================================
// SECDED(39,32) encoder, combinational check-bit generation
// ==========================================================

module secded_39_32_enc
  import hci_ecc_pkg::*;
(
  input  data_t data_i,
  output ecc_t  ecc_o
);

  // running xor of the columns of all set data bits
  ecc_t ecc_acc;

  always_comb begin
    ecc_acc = '0;
    // every set data bit toggles the check bits of its column
    for (int i = 0; i < DATA_W; i++) begin
      if (data_i[i]) begin
        ecc_acc = ecc_acc ^ ECC_COLUMNS[i];
      end
    end
  end

  // columns have weight 3, so each data bit feeds three checks
  // zero data gives zero check bits
  assign ecc_o = ecc_acc;

endmodule

// File: tb_hci_ecc_mem.sv
// ==========================================================
// random read/write traffic with link fault injection, checked
// against a word-array model that rebuilds the SECDED code
// ==========================================================

module tb_hci_ecc_mem
  import hci_ecc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CW_W    = ECC_W + DATA_W;
  localparam int TIMEOUT = 20;

  logic            clk;
  logic            rst;
  logic            req;
  logic            gnt;
  addr_t           add;
  logic            wen;
  be_t             be;
  data_t           wdata;
  logic            rvalid;
  data_t           rdata;
  logic [CW_W-1:0] wr_flip;
  logic [CW_W-1:0] rd_flip;
  err_t            wr_err;
  ecc_t            wr_syn;
  err_t            rd_err;
  ecc_t            rd_syn;

  // model of the bank contents and of the code columns
  data_t       model_mem [MEM_DEPTH];
  ecc_t        cols [DATA_W];
  logic [31:0] lcg_state;
  int          n_checks;

  hci_ecc_mem_top hci_ecc_mem_top_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .req_i         (req),
    .gnt_o         (gnt),
    .add_i         (add),
    .wen_i         (wen),
    .be_i          (be),
    .data_i        (wdata),
    .rvalid_o      (rvalid),
    .rdata_o       (rdata),
    .wr_flip_i     (wr_flip),
    .rd_flip_i     (rd_flip),
    .wr_err_o      (wr_err),
    .wr_syndrome_o (wr_syn),
    .rd_err_o      (rd_err),
    .rd_syndrome_o (rd_syn)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // fold high bits down, low LCG bits have short periods
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = next_rand();
    return r[ADDR_W+11:12];
  endfunction

  // weight-3 values in ascending order, first DATA_W of them
  function automatic void build_columns();
    int   n;
    ecc_t cand;
    n = 0;
    for (int v = 0; v < (1 << ECC_W); v++) begin
      cand = ecc_t'(v);
      if ($countones(cand) == 3 && n < DATA_W) begin
        cols[n] = cand;
        n++;
      end
    end
  endfunction

  function automatic ecc_t model_encode(input data_t d);
    ecc_t e;
    e = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (d[i]) begin
        e = e ^ cols[i];
      end
    end
    return e;
  endfunction

  // syndrome parity picks the class, odd weight flips a matching data bit
  function automatic void model_decode(input data_t d, input ecc_t e, output data_t fixed,
                                       output ecc_t syn, output err_t err);
    syn   = e ^ model_encode(d);
    fixed = d;
    if (syn == '0) begin
      err = 2'b00;
    end else if ($countones(syn) % 2 == 1) begin
      err = 2'b01;
      for (int i = 0; i < DATA_W; i++) begin
        if (cols[i] == syn) begin
          fixed[i] = ~d[i];
        end
      end
    end else begin
      err = 2'b10;
    end
  endfunction

  // mask with exactly nbits distinct codeword bits set
  function automatic logic [CW_W-1:0] make_flip(input int nbits);
    logic [CW_W-1:0] f;
    logic [5:0]      pos;
    f = '0;
    for (int t = 0; t < 200 && $countones(f) < nbits; t++) begin
      pos    = 6'(next_rand() % CW_W);
      f[pos] = 1'b1;
    end
    return f;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_err(input string what, input err_t got, input err_t exp);
    n_checks++;
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_ecc(input string what, input ecc_t got, input ecc_t exp);
    n_checks++;
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic drive_idle();
    req     = 1'b0;
    wen     = 1'b1;
    add     = '0;
    be      = '0;
    wdata   = '0;
    wr_flip = '0;
    rd_flip = '0;
  endtask

  // one write cycle, status is combinational in the request cycle
  task automatic do_write(input addr_t a, input be_t b, input data_t d,
                          input logic [CW_W-1:0] flip);
    data_t sent;
    ecc_t  sent_ecc;
    data_t exp_data;
    ecc_t  exp_syn;
    err_t  exp_err;
    @(negedge clk);
    req     = 1'b1;
    wen     = 1'b0;
    add     = a;
    be      = b;
    wdata   = d;
    wr_flip = flip;
    rd_flip = '0;
    {sent_ecc, sent} = {model_encode(d), d} ^ flip;
    model_decode(sent, sent_ecc, exp_data, exp_syn, exp_err);
    #1;
    check_flag("write grant", gnt, 1'b1);
    check_flag("rvalid_o during write", rvalid, 1'b0);
    check_err("write error class", wr_err, exp_err);
    check_ecc("write syndrome", wr_syn, exp_syn);
    // double errors land in the bank uncorrected
    for (int l = 0; l < DATA_W / 8; l++) begin
      if (b[l]) begin
        model_mem[a][8*l +: 8] = exp_data[8*l +: 8];
      end
    end
  endtask

  task automatic do_read(input addr_t a, input logic [CW_W-1:0] flip);
    int    cycles;
    data_t stored;
    data_t rx;
    ecc_t  rx_ecc;
    data_t exp_data;
    ecc_t  exp_syn;
    err_t  exp_err;
    @(negedge clk);
    check_flag("rvalid_o before read", rvalid, 1'b0);
    req     = 1'b1;
    wen     = 1'b1;
    add     = a;
    be      = be_t'(next_rand());
    wdata   = next_rand();
    wr_flip = '0;
    rd_flip = flip;
    #1;
    check_flag("read grant", gnt, 1'b1);
    cycles = 0;
    do begin
      @(negedge clk);
      req = 1'b0;
      cycles++;
    end while (rvalid !== 1'b1 && cycles < TIMEOUT);
    if (rvalid !== 1'b1) begin
      fail_stop($sformatf("no read response within %0d cycles for address %h", TIMEOUT, a));
    end
    if (cycles != 1) begin
      fail_stop($sformatf("read response came after %0d cycles instead of 1", cycles));
    end
    stored = model_mem[a];
    {rx_ecc, rx} = {model_encode(stored), stored} ^ flip;
    model_decode(rx, rx_ecc, exp_data, exp_syn, exp_err);
    check_data("read data", rdata, exp_data);
    check_err("read error class", rd_err, exp_err);
    check_ecc("read syndrome", rd_syn, exp_syn);
  endtask

  // reads on consecutive cycles, each response one cycle behind its request
  task automatic read_burst(input int n);
    addr_t q[$];
    addr_t a;
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i > 0) begin
        a = q.pop_front();
        check_flag("burst rvalid_o", rvalid, 1'b1);
        check_data("burst read data", rdata, model_mem[a]);
        check_err("burst read error class", rd_err, 2'b00);
      end else begin
        check_flag("rvalid_o before burst", rvalid, 1'b0);
      end
      if (i < n) begin
        a = rand_addr();
        q.push_back(a);
        req     = 1'b1;
        wen     = 1'b1;
        add     = a;
        wr_flip = '0;
        rd_flip = '0;
      end else begin
        req = 1'b0;
      end
    end
    @(negedge clk);
    check_flag("rvalid_o after burst", rvalid, 1'b0);
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    lcg_state = 32'd91590;
    n_checks  = 0;
    build_columns();
    rst = 1'b1;
    drive_idle();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_flag("rvalid_o after reset", rvalid, 1'b0);
    // fill every word so reads never see an unwritten location
    for (int i = 0; i < MEM_DEPTH; i++) begin
      do_write(addr_t'(i), 4'hf, next_rand(), '0);
    end
    // clean mix of writes with random lanes and reads
    repeat (300) begin
      r = next_rand();
      if (r[20]) begin
        do_write(rand_addr(), be_t'(next_rand()), next_rand(), '0);
      end else begin
        do_read(rand_addr(), '0);
      end
    end
    // faults on the request codeword
    repeat (60) begin
      a = rand_addr();
      do_write(a, be_t'(next_rand()), next_rand(), make_flip(1));
      do_read(a, '0);
    end
    repeat (40) begin
      a = rand_addr();
      do_write(a, be_t'(next_rand()), next_rand(), make_flip(2));
      do_read(a, '0);
    end
    // faults on the response codeword
    repeat (60) do_read(rand_addr(), make_flip(1));
    repeat (40) do_read(rand_addr(), make_flip(2));
    repeat (10) read_burst(8);
    @(negedge clk);
    drive_idle();
    $display("%0d checks run", n_checks);
    $display("All checks passed");
    $finish;
  end

endmodule
